/* Makefile */
# Verilator build and run of the spi control path testbench

VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := tb_smu_ctrl
FILELIST  := tb.f
OBJ_DIR   := obj_dir
RUNFLAGS  := +verilator+error+limit+1000
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, look for the pass message"
	@echo "make clean  remove $(OBJ_DIR)"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* ctrl_reg_file.sv */
////////////////////////////////////////
// ten 4 bit control registers with set, clear and toggle
// unknown addresses are ignored, soft reset restores per register values
////////////////////////////////////////

`timescale 1ns/1ns
`include "smu_ctrl_config.svh"

module ctrl_reg_file
  import smu_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  spi_frame_t frame,
  output ctrl_regs_t regs
);

  ////////////////////////////////////////
  // reset values

  // shared by hard reset and the soft reset address
  localparam ctrl_regs_t RST_VALS = '{
    led:         `SMU_RST_DEFAULT,
    mux:         `SMU_RST_DEFAULT,
    dac:         `SMU_RST_DEFAULT,
    rails:       `SMU_RST_DEFAULT,
    dac_ref_mux: `SMU_RST_DAC_REF_MUX,
    adc:         `SMU_RST_DEFAULT,
    clamp1:      `SMU_RST_CLAMP1,
    clamp2:      `SMU_RST_CLAMP2,
    relay_com:   `SMU_RST_DEFAULT,
    rails_oe:    `SMU_RST_RAILS_OE
  };

  ////////////////////////////////////////
  // update rule

  // low nibble sets, high nibble clears
  // a bit both set and cleared toggles
  function automatic ctrl_nib_t apply_cmd(input ctrl_nib_t old, input reg_cmd_t cmd);
    ctrl_nib_t set_b;
    ctrl_nib_t clr_b;
    ctrl_nib_t both;
    set_b = cmd[`SMU_REG_W-1:0];
    clr_b = cmd[`SMU_CMD_W-1 -: `SMU_REG_W];
    both  = set_b & clr_b;
    // toggle wins, other bits untouched
    if (|both)
      return old ^ both;
    // set first, then clear
    return (old | set_b) & ~clr_b;
  endfunction

  ////////////////////////////////////////
  // register bank

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      regs <= RST_VALS;
    else if (frame.valid)
    begin
      case (frame.addr)
        // leds
        `SMU_ADDR_LED:         regs.led <= apply_cmd(regs.led, frame.cmd);
        // peripheral chip select routing
        `SMU_ADDR_MUX:         regs.mux <= apply_cmd(regs.mux, frame.cmd);
        // dac control lines
        `SMU_ADDR_DAC:         regs.dac <= apply_cmd(regs.dac, frame.cmd);
        `SMU_ADDR_RAILS:       regs.rails <= apply_cmd(regs.rails, frame.cmd);
        // everything back to power up state
        `SMU_ADDR_SOFT_RESET:  regs <= RST_VALS;
        `SMU_ADDR_DAC_REF_MUX:
        begin
          regs.dac_ref_mux <= apply_cmd(regs.dac_ref_mux, frame.cmd);
        end
        // adc02 reset and mode pins
        `SMU_ADDR_ADC:         regs.adc <= apply_cmd(regs.adc, frame.cmd);
        // clamps are active low
        `SMU_ADDR_CLAMP1:      regs.clamp1 <= apply_cmd(regs.clamp1, frame.cmd);
        `SMU_ADDR_CLAMP2:      regs.clamp2 <= apply_cmd(regs.clamp2, frame.cmd);
        `SMU_ADDR_RELAY_COM:
        begin
          regs.relay_com <= apply_cmd(regs.relay_com, frame.cmd);
        end
        // rails enable, bit 0 high keeps rails off
        `SMU_ADDR_RAILS_OE:    regs.rails_oe <= apply_cmd(regs.rails_oe, frame.cmd);
        // unmapped address, nothing changes
        default:               regs <= regs;
      endcase
    end
  end

endmodule

/* smu_ctrl_config.svh */
////////////////////////////////////////
// widths, addresses and reset values of the control path
// addresses are 8 bit literals so they compare directly against the address byte
////////////////////////////////////////

`ifndef SMU_CTRL_CONFIG_SVH
`define SMU_CTRL_CONFIG_SVH

// control register width
`define SMU_REG_W            4
// frame fields
`define SMU_ADDR_W           8
`define SMU_CMD_W            8
`define SMU_FRAME_BITS       16
// frame bit counter width, saturates at all ones
`define SMU_CNT_W            5
// routed peripherals adc03, dac, flash, adc02
`define SMU_N_PERIPH         4
// synchronizer depth on raw spi lines
`define SMU_SYNC_STAGES      2

// register map
`define SMU_ADDR_LED         8'd7
`define SMU_ADDR_MUX         8'd8
`define SMU_ADDR_DAC         8'd9
`define SMU_ADDR_RAILS       8'd10
`define SMU_ADDR_SOFT_RESET  8'd11
`define SMU_ADDR_DAC_REF_MUX 8'd12
`define SMU_ADDR_ADC         8'd14
`define SMU_ADDR_CLAMP1      8'd15
`define SMU_ADDR_CLAMP2      8'd16
`define SMU_ADDR_RELAY_COM   8'd17
`define SMU_ADDR_RAILS_OE    8'd24

// reset values
`define SMU_RST_DEFAULT      4'h0
// active low switches come up off
`define SMU_RST_DAC_REF_MUX  4'hF
`define SMU_RST_CLAMP1       4'hF
`define SMU_RST_CLAMP2       4'hF
// rails output enable held off until firmware turns rails on
`define SMU_RST_RAILS_OE     4'h1

`endif

/* smu_ctrl_pkg.sv */
////////////////////////////////////////
// shared types for the spi control path
// widths follow the config header
////////////////////////////////////////

`include "smu_ctrl_config.svh"

package smu_ctrl_pkg;

  // meaningful widths
  typedef logic [`SMU_REG_W-1:0]    ctrl_nib_t;
  typedef logic [`SMU_ADDR_W-1:0]   reg_addr_t;
  typedef logic [`SMU_CMD_W-1:0]    reg_cmd_t;
  typedef logic [`SMU_N_PERIPH-1:0] periph_vec_t;
  typedef logic [`SMU_CNT_W-1:0]    bit_cnt_t;

  // frame receiver fsm
  typedef enum logic [1:0] {
    idle,
    shift,
    done
  } rx_state_t;

  // synced spi events, strobes are one clk wide
  typedef struct packed {
    logic sclk_rise;
    logic mosi;
    logic frame_start;
    logic frame_end;
    logic special_n;
  } spi_evt_t;

  // complete frame, high byte address and low byte command
  typedef struct packed {
    logic      valid;
    reg_addr_t addr;
    reg_cmd_t  cmd;
  } spi_frame_t;

  // register bank as seen by the board pins
  typedef struct packed {
    ctrl_nib_t led;
    ctrl_nib_t mux;
    ctrl_nib_t dac;
    ctrl_nib_t rails;
    ctrl_nib_t dac_ref_mux;
    ctrl_nib_t adc;
    ctrl_nib_t clamp1;
    ctrl_nib_t clamp2;
    ctrl_nib_t relay_com;
    ctrl_nib_t rails_oe;
  } ctrl_regs_t;

endpackage

/* smu_ctrl_properties.sv */
////////////////////////////////////////
// bound into smu_ctrl_top
// routing checked at every clk
// reset values checked on the first clk out of reset
////////////////////////////////////////

`timescale 1ns/1ns
`include "smu_ctrl_config.svh"

module smu_ctrl_properties
  import smu_ctrl_pkg::*;
(
  input logic        clk,
  input logic        rst_n,
  input logic        cs_n,
  input logic        special_n,
  input periph_vec_t periph_miso,
  input periph_vec_t periph_cs_n,
  input logic        miso,
  input ctrl_regs_t  regs
);

  // one failure counter per assertion
  int cs_fail   = 0;
  int miso_fail = 0;
  int rst_fail  = 0;
  int fail_cnt;

  assign fail_cnt = cs_fail + miso_fail + rst_fail;

  // chip select follows mux only during peripheral traffic
  a_cs_route: assert property (@(posedge clk)
    periph_cs_n == ((!special_n && !cs_n) ? ~regs.mux : {`SMU_N_PERIPH{1'b1}}))
  else
  begin
    cs_fail++;
    $error("periph_cs_n does not match mux, cs_n and special_n");
  end

  // or of the enabled peripheral outputs
  a_miso_sel: assert property (@(posedge clk)
    miso == (!special_n && ((regs.mux & periph_miso) != '0)))
  else
  begin
    miso_fail++;
    $error("miso does not match the selected peripherals");
  end

  ////////////////////////////////////////
  // reset values

  a_rst_vals: assert property (@(posedge clk)
    $rose(rst_n) |-> (regs.led == 4'h0 && regs.mux == 4'h0 && regs.dac == 4'h0 &&
                      regs.rails == 4'h0 && regs.dac_ref_mux == `SMU_RST_DAC_REF_MUX &&
                      regs.adc == 4'h0 && regs.clamp1 == `SMU_RST_CLAMP1 &&
                      regs.clamp2 == `SMU_RST_CLAMP2 && regs.relay_com == 4'h0 &&
                      regs.rails_oe == `SMU_RST_RAILS_OE))
  else
  begin
    rst_fail++;
    $error("register bank not at reset values after reset");
  end

endmodule

bind smu_ctrl_top smu_ctrl_properties u_props (
  .clk         (clk),
  .rst_n       (rst_n),
  .cs_n        (cs_n),
  .special_n   (special_n),
  .periph_miso (periph_miso),
  .periph_cs_n (periph_cs_n),
  .miso        (miso),
  .regs        (regs)
);

/* smu_ctrl_top.sv */
////////////////////////////////////////
// spi control path of the smu board fpga
// sclk, mosi and adc drdy go straight through to the board
////////////////////////////////////////

`timescale 1ns/1ns
`include "smu_ctrl_config.svh"

module smu_ctrl_top
  import smu_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  // host spi
  input  logic        sclk,
  input  logic        cs_n,
  input  logic        mosi,
  input  logic        special_n,
  output logic        miso,
  // peripheral spi
  input  periph_vec_t periph_miso,
  output logic        periph_sclk,
  output logic        periph_mosi,
  output periph_vec_t periph_cs_n,
  // adc02 data ready, active low
  input  logic        adc_drdy_n,
  output logic        irq_n,
  // register bank to the board pins
  output ctrl_regs_t  regs
);

  spi_evt_t   evt;
  spi_frame_t frame;

  ////////////////////////////////////////
  // pass through

  // shared by all peripherals
  assign periph_sclk = sclk;
  assign periph_mosi = mosi;
  // single interrupt source for now
  assign irq_n = adc_drdy_n;

  ////////////////////////////////////////
  // register path

  spi_input_sync u_sync (
    .clk       (clk),
    .rst_n     (rst_n),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .special_n (special_n),
    .evt       (evt)
  );

  spi_frame_rx u_rx (
    .clk   (clk),
    .rst_n (rst_n),
    .evt   (evt),
    .frame (frame)
  );

  ctrl_reg_file u_regs (
    .clk   (clk),
    .rst_n (rst_n),
    .frame (frame),
    .regs  (regs)
  );

  // routing works on the raw lines with no clk delay
  spi_periph_router u_route (
    .cs_n        (cs_n),
    .special_n   (special_n),
    .mux         (regs.mux),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .miso        (miso)
  );

endmodule

/* spi_frame_rx.sv */
////////////////////////////////////////
// collects one spi frame between cs_n fall and rise
// only exact 16 bit frames with special_n high are passed on
////////////////////////////////////////

`timescale 1ns/1ns
`include "smu_ctrl_config.svh"

module spi_frame_rx
  import smu_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  spi_evt_t   evt,
  output spi_frame_t frame
);

  rx_state_t state_q;
  bit_cnt_t  bit_cnt_q;
  // frame payload, first bit ends up in the msb
  logic [`SMU_FRAME_BITS-1:0] shreg_q;
  logic shift_en;
  logic frame_ok;

  // no shifting on the closing cycle
  assign shift_en = (state_q == shift) && evt.sclk_rise && !evt.frame_end;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state_q   <= idle;
      bit_cnt_q <= '0;
    end
    else
    begin
      case (state_q)
        idle:
        begin
          if (evt.frame_start)
          begin
            state_q   <= shift;
            bit_cnt_q <= '0;
          end
        end
        shift:
        begin
          if (evt.frame_end)
            state_q <= done;
          // saturate so long frames never wrap back to 16
          else if (shift_en && bit_cnt_q != '1)
            bit_cnt_q <= bit_cnt_q + 1'b1;
        end
        // one cycle for the valid strobe
        default: state_q <= idle;
      endcase
    end
  end

  // d into lsb, shift toward msb
  always_ff @(posedge clk)
  begin
    if (shift_en)
      shreg_q <= {shreg_q[`SMU_FRAME_BITS-2:0], evt.mosi};
  end

  // peripheral traffic with special_n low is not for the bank
  assign frame_ok = (bit_cnt_q == bit_cnt_t'(`SMU_FRAME_BITS)) && evt.special_n;

  assign frame = '{valid: (state_q == done) && frame_ok,
                   addr:  shreg_q[`SMU_FRAME_BITS-1 -: `SMU_ADDR_W],
                   cmd:   shreg_q[`SMU_CMD_W-1:0]};

endmodule

/* spi_input_sync.sv */
////////////////////////////////////////
// brings raw spi lines into the clk domain
// strobes lag the raw edge by 3 clk, host half period must be >= 4 clk
////////////////////////////////////////

`timescale 1ns/1ns
`include "smu_ctrl_config.svh"

module spi_input_sync
  import smu_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     sclk,
  input  logic     cs_n,
  input  logic     mosi,
  input  logic     special_n,
  output spi_evt_t evt
);

  // line order {sclk, cs_n, mosi, special_n}
  // idle levels with bus released
  localparam logic [3:0] LINE_IDLE = 4'b0101;

  logic [`SMU_SYNC_STAGES-1:0][3:0] sync_q;
  logic sclk_s;
  logic cs_n_s;
  logic mosi_s;
  logic special_n_s;
  // previous synced levels for edge detect
  logic sclk_prev;
  logic cs_n_prev;

  // last stage of the chain
  assign {sclk_s, cs_n_s, mosi_s, special_n_s} = sync_q[`SMU_SYNC_STAGES-1];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sync_q    <= {`SMU_SYNC_STAGES{LINE_IDLE}};
      sclk_prev <= 1'b0;
      cs_n_prev <= 1'b1;
      evt       <= '{sclk_rise: 1'b0, mosi: 1'b0, frame_start: 1'b0,
                     frame_end: 1'b0, special_n: 1'b1};
    end
    else
    begin
      // raw lines enter at stage 0
      sync_q    <= {sync_q[`SMU_SYNC_STAGES-2:0], {sclk, cs_n, mosi, special_n}};
      sclk_prev <= sclk_s;
      cs_n_prev <= cs_n_s;
      // registered strobes
      evt.sclk_rise   <= sclk_s & ~sclk_prev;
      // cs_n fall opens a frame, rise closes it
      evt.frame_start <= ~cs_n_s & cs_n_prev;
      evt.frame_end   <= cs_n_s & ~cs_n_prev;
      // levels kept aligned with the strobes
      evt.mosi        <= mosi_s;
      evt.special_n   <= special_n_s;
    end
  end

endmodule

/* spi_periph_router.sv */
////////////////////////////////////////
// combinational chip select fan out and miso select
// peripherals only see cs_n while special_n is low
////////////////////////////////////////

`timescale 1ns/1ns
`include "smu_ctrl_config.svh"

module spi_periph_router
  import smu_ctrl_pkg::*;
(
  input  logic        cs_n,
  input  logic        special_n,
  input  ctrl_nib_t   mux,
  input  periph_vec_t periph_miso,
  output periph_vec_t periph_cs_n,
  output logic        miso
);

  // one mux bit per peripheral
  periph_vec_t sel;

  assign sel = mux[`SMU_N_PERIPH-1:0];

  // special_n high means the host talks to the bank
  // keep every peripheral deselected then
  assign periph_cs_n = (special_n || cs_n) ? '1 : ~sel;

  // or of selected peripheral outputs
  // bank has no readback so miso stays 0 with special_n high
  assign miso = !special_n && (|(sel & periph_miso));

endmodule

/* tb.f */
+incdir+.
smu_ctrl_pkg.sv
spi_input_sync.sv
spi_frame_rx.sv
ctrl_reg_file.sv
spi_periph_router.sv
smu_ctrl_top.sv
smu_ctrl_properties.sv
tb_smu_ctrl.sv

/* tb_smu_ctrl.sv */
////////////////////////////////////////
// testbench for the spi control path with a host half period of 4 clk
// regs compared with a shadow model 8 clk after each frame
////////////////////////////////////////

`timescale 1ns/1ns
`include "smu_ctrl_config.svh"

module tb_smu_ctrl
  import smu_ctrl_pkg::*;
();

  // 60 random, 6 malformed, 5 soft reset, 1 mux write
  localparam int N_FRAMES   = 72;
  // frames x bits x 8 clk x 10 ns plus half again
  localparam int TIMEOUT_NS = N_FRAMES * `SMU_FRAME_BITS * 8 * 10 * 3 / 2;
  localparam int HALF_CLKS  = 4;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        sclk;
  logic        cs_n;
  logic        mosi;
  logic        special_n;
  periph_vec_t periph_miso;
  logic        adc_drdy_n;
  logic        miso;
  logic        periph_sclk;
  logic        periph_mosi;
  periph_vec_t periph_cs_n;
  logic        irq_n;
  ctrl_regs_t  regs;

  // shadow of the register bank
  ctrl_regs_t  model;
  logic [31:0] rng = 32'h24d;
  int          err_cnt = 0;
  // kept register addresses without soft reset
  reg_addr_t   kept_addr [10] = '{`SMU_ADDR_LED, `SMU_ADDR_MUX, `SMU_ADDR_DAC,
                                  `SMU_ADDR_RAILS, `SMU_ADDR_DAC_REF_MUX, `SMU_ADDR_ADC,
                                  `SMU_ADDR_CLAMP1, `SMU_ADDR_CLAMP2, `SMU_ADDR_RELAY_COM,
                                  `SMU_ADDR_RAILS_OE};

  smu_ctrl_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .special_n   (special_n),
    .miso        (miso),
    .periph_miso (periph_miso),
    .periph_sclk (periph_sclk),
    .periph_mosi (periph_mosi),
    .periph_cs_n (periph_cs_n),
    .adc_drdy_n  (adc_drdy_n),
    .irq_n       (irq_n),
    .regs        (regs)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////
  // random source and reference model

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // low nibble sets, high nibble clears, a bit in both flips
  function automatic ctrl_nib_t model_update(input ctrl_nib_t old, input reg_cmd_t cmd);
    ctrl_nib_t set_b;
    ctrl_nib_t clr_b;
    ctrl_nib_t res;
    ctrl_nib_t m;
    logic      any_both;
    set_b    = cmd[3:0];
    clr_b    = cmd[7:4];
    res      = old;
    any_both = 1'b0;
    for (int i = 0; i < `SMU_REG_W; i++)
    begin
      m = ctrl_nib_t'(1) << i;
      if ((set_b & clr_b & m) != '0)
        any_both = 1'b1;
    end
    for (int i = 0; i < `SMU_REG_W; i++)
    begin
      m = ctrl_nib_t'(1) << i;
      // toggle mode leaves single set or clear bits alone
      if (any_both)
      begin
        if ((set_b & clr_b & m) != '0)
          res = res ^ m;
      end
      else if ((clr_b & m) != '0)
        res = res & ~m;
      else if ((set_b & m) != '0)
        res = res | m;
    end
    return res;
  endfunction

  task automatic model_reset();
    model = '{led: 4'h0, mux: 4'h0, dac: 4'h0, rails: 4'h0,
              dac_ref_mux: `SMU_RST_DAC_REF_MUX, adc: 4'h0,
              clamp1: `SMU_RST_CLAMP1, clamp2: `SMU_RST_CLAMP2,
              relay_com: 4'h0, rails_oe: `SMU_RST_RAILS_OE};
  endtask

  task automatic model_write(input reg_addr_t addr, input reg_cmd_t cmd);
    case (addr)
      `SMU_ADDR_LED:         model.led = model_update(model.led, cmd);
      `SMU_ADDR_MUX:         model.mux = model_update(model.mux, cmd);
      `SMU_ADDR_DAC:         model.dac = model_update(model.dac, cmd);
      `SMU_ADDR_RAILS:       model.rails = model_update(model.rails, cmd);
      `SMU_ADDR_SOFT_RESET:  model_reset();
      `SMU_ADDR_DAC_REF_MUX: model.dac_ref_mux = model_update(model.dac_ref_mux, cmd);
      `SMU_ADDR_ADC:         model.adc = model_update(model.adc, cmd);
      `SMU_ADDR_CLAMP1:      model.clamp1 = model_update(model.clamp1, cmd);
      `SMU_ADDR_CLAMP2:      model.clamp2 = model_update(model.clamp2, cmd);
      `SMU_ADDR_RELAY_COM:   model.relay_com = model_update(model.relay_com, cmd);
      `SMU_ADDR_RAILS_OE:    model.rails_oe = model_update(model.rails_oe, cmd);
      default: ;
    endcase
  endtask

  ////////////////////////////////////////
  // checks sampled on the falling edge

  task automatic check_field(input string name, input ctrl_nib_t exp, input ctrl_nib_t act);
    assert (act === exp)
    else
    begin
      err_cnt++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    assert (act === exp)
    else
    begin
      err_cnt++;
      $display("FAIL %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_regs();
    @(negedge clk);
    check_field("regs.led", model.led, regs.led);
    check_field("regs.mux", model.mux, regs.mux);
    check_field("regs.dac", model.dac, regs.dac);
    check_field("regs.rails", model.rails, regs.rails);
    check_field("regs.dac_ref_mux", model.dac_ref_mux, regs.dac_ref_mux);
    check_field("regs.adc", model.adc, regs.adc);
    check_field("regs.clamp1", model.clamp1, regs.clamp1);
    check_field("regs.clamp2", model.clamp2, regs.clamp2);
    check_field("regs.relay_com", model.relay_com, regs.relay_com);
    check_field("regs.rails_oe", model.rails_oe, regs.rails_oe);
  endtask

  // peripheral i selected only with special_n, cs_n and its mux bit all active
  task automatic check_routing();
    periph_vec_t exp_cs;
    logic        exp_miso;
    @(negedge clk);
    exp_cs   = '1;
    exp_miso = 1'b0;
    for (int i = 0; i < `SMU_N_PERIPH; i++)
    begin
      if (special_n == 1'b0 && model.mux[i] == 1'b1)
      begin
        if (cs_n == 1'b0)
          exp_cs[i] = 1'b0;
        // miso ignores cs_n
        if (periph_miso[i] == 1'b1)
          exp_miso = 1'b1;
      end
    end
    check_field("periph_cs_n", exp_cs, periph_cs_n);
    check_bit("miso", exp_miso, miso);
    check_bit("periph_sclk", sclk, periph_sclk);
    check_bit("periph_mosi", mosi, periph_mosi);
    check_bit("irq_n", adc_drdy_n, irq_n);
  endtask

  ////////////////////////////////////////
  // host side stimulus

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
  endtask

  // sent msb first
  // nbits other than 16 gives a malformed frame
  task automatic send_frame(input logic [16:0] data, input int nbits);
    logic [16:0] data_sh;
    data_sh = data << (17 - nbits);
    @(posedge clk);
    cs_n <= 1'b0;
    wait_clks(HALF_CLKS);
    for (int i = 0; i < nbits; i++)
    begin
      mosi    <= data_sh[16];
      data_sh = data_sh << 1;
      wait_clks(HALF_CLKS);
      sclk <= 1'b1;
      wait_clks(HALF_CLKS);
      sclk <= 1'b0;
    end
    wait_clks(HALF_CLKS);
    cs_n <= 1'b1;
    // sync, receiver and bank take 5 clk
    wait_clks(8);
  endtask

  task automatic write_reg(input reg_addr_t addr, input reg_cmd_t cmd);
    send_frame({1'b0, addr, cmd}, 16);
    model_write(addr, cmd);
    check_regs();
  endtask

  // random cs_n, miso and pass-through lines on one side of special_n
  task automatic route_phase(input logic spec_n, input int cycles);
    logic [31:0] r;
    @(posedge clk);
    special_n <= spec_n;
    for (int n = 0; n < cycles; n++)
    begin
      r = next_rand();
      @(posedge clk);
      cs_n        <= r[0];
      periph_miso <= r[7:4];
      mosi        <= r[8];
      adc_drdy_n  <= r[9];
      // bank side keeps sclk still so no frame can complete
      sclk        <= r[10] & ~spec_n;
      check_routing();
    end
    @(posedge clk);
    cs_n <= 1'b1;
    sclk <= 1'b0;
    // drain any partial frame before special_n moves
    wait_clks(8);
  endtask

  ////////////////////////////////////////
  // test sequence

  initial
  begin
    logic [31:0] r;
    logic [3:0]  idx;
    reg_cmd_t    cmd;
    int          total_err;
    rst_n       <= 1'b0;
    sclk        <= 1'b0;
    cs_n        <= 1'b1;
    mosi        <= 1'b0;
    special_n   <= 1'b1;
    periph_miso <= '0;
    adc_drdy_n  <= 1'b1;
    model_reset();
    wait_clks(10);
    rst_n <= 1'b1;
    wait_clks(2);
    // power up values with nothing selected
    check_regs();
    check_field("periph_cs_n", 4'hF, periph_cs_n);

    // random set, clear and toggle traffic
    for (int n = 0; n < 60; n++)
    begin
      r   = next_rand();
      idx = 4'(r[7:0] % 8'd10);
      cmd = r[15:8];
      // same bits set and cleared give a pure toggle
      if (n % 5 == 0)
        cmd = {r[11:8] | 4'h1, r[11:8] | 4'h1};
      // one bit in both with the rest plain set or clear
      else if (n % 5 == 1)
        cmd = {r[11:8] | 4'h2, r[19:16] | 4'h2};
      write_reg(kept_addr[idx], cmd);
    end

    // short, long and unmapped frames are dropped
    send_frame({1'b0, `SMU_ADDR_LED, 8'h0F}, 15);
    send_frame({1'b1, `SMU_ADDR_DAC, 8'h0F}, 17);
    send_frame({1'b0, 8'd13, 8'h0F}, 16);
    send_frame({1'b0, 8'hC3, 8'hF0}, 16);
    check_regs();
    // peripheral traffic never reaches the bank
    @(posedge clk);
    special_n <= 1'b0;
    send_frame({1'b0, `SMU_ADDR_CLAMP1, 8'hF0}, 16);
    send_frame({1'b0, `SMU_ADDR_RAILS_OE, 8'h0E}, 16);
    @(posedge clk);
    special_n <= 1'b1;
    check_regs();

    // move reset values away before the soft reset
    write_reg(`SMU_ADDR_DAC_REF_MUX, 8'hF0);
    write_reg(`SMU_ADDR_RAILS_OE, 8'h1E);
    write_reg(`SMU_ADDR_LED, 8'h05);
    write_reg(`SMU_ADDR_CLAMP1, 8'h30);
    write_reg(`SMU_ADDR_SOFT_RESET, 8'h00);

    // routing with at least one peripheral enabled
    r = next_rand();
    write_reg(`SMU_ADDR_MUX, {4'h0, r[3:0] | 4'h1});
    route_phase(1'b0, 20);
    route_phase(1'b1, 12);
    check_regs();

    total_err = err_cnt + u_dut.u_props.fail_cnt;
    $display("errors: %0d in checks, %0d in assertions", err_cnt, u_dut.u_props.fail_cnt);
    if (total_err == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

  // watchdog
  initial
  begin
    #TIMEOUT_NS;
    $display("timeout after %0d ns, the frame sequence did not finish", TIMEOUT_NS);
    $display("Some tests failed");
    $finish;
  end

endmodule
